/* hw/pll_params.svh */
`ifndef PLL_PARAMS_SVH
`define PLL_PARAMS_SVH

// ====================
// loop widths
// ====================
`define PLL_PHASE_WIDTH     32    // phase, increment and center frequency.
`define PLL_ERROR_WIDTH     8     // signed up/down count of the comparator.
`define PLL_GAIN_WIDTH      5     // shift code of the loop filter.

// ====================
// register map
// ====================
`define PLL_ADDR_WIDTH      4
`define PLL_REG_CENTER_FREQ 4'd0  // read/write, byte enabled.
`define PLL_REG_GAIN        4'd1  // read/write, low 5 bits only.
`define PLL_REG_PHASE_ERROR 4'd2  // read only, sign extended.
`define PLL_REG_PHASE_INC   4'd3  // read only.

// ====================
// saturation limits
// ====================
`define PLL_INC_MAX         32'h7FFF_FFFF
`define PLL_INC_MIN         32'h0000_0000

`endif

/* hw/pllBusPkg.sv */
`default_nettype none

`include "pll_params.svh"

package pllBusPkg;

    // Host side of the register block.
    typedef logic [`PLL_ADDR_WIDTH-1:0] regAddrT;  // word offset in the register window.
    typedef logic [31:0]                busDataT;  // one bus data word.
    typedef logic [3:0]                 byteEnT;   // one enable per byte lane.

endpackage

`default_nettype wire

/* hw/pllLoopPkg.sv */
`default_nettype none

`include "pll_params.svh"

package pllLoopPkg;

    // Values that travel around the loop.
    typedef logic [`PLL_PHASE_WIDTH-1:0]        phaseT;       // phase, increment or frequency.
    typedef logic signed [`PLL_ERROR_WIDTH-1:0] phaseErrorT;  // wraps modulo 256.
    typedef logic [`PLL_GAIN_WIDTH-1:0]         loopGainT;    // 0 turns the loop off.

endpackage

`default_nettype wire

/* hw/pllRegisterFile.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pll_params.svh"

module pllRegisterFile
    import pllBusPkg::*, pllLoopPkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        reqValid,
    input  wire        reqWrite,
    input  regAddrT    reqAddr,
    input  byteEnT     reqByteEn,
    input  busDataT    reqData,
    output logic       reqReady,
    output logic       rspValid,
    output busDataT    rspData,
    input  wire        rspReady,
    input  phaseErrorT phaseError,
    input  phaseT      phaseInc,
    output phaseT      centerFreq,
    output loopGainT   loopGain
);

    logic    reqFire;
    logic    writeFire;
    logic    readFire;
    busDataT readData;

    // a new request is taken once the pending response leaves.
    assign reqReady  = !rspValid || rspReady;
    assign reqFire   = reqValid && reqReady;
    assign writeFire = reqFire && reqWrite;
    assign readFire  = reqFire && !reqWrite;

    // ====================
    // write path
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            centerFreq <= '0;
            loopGain   <= '0;
        end else if (writeFire) begin
            case (reqAddr)
                `PLL_REG_CENTER_FREQ: begin
                    for (int lane = 0; lane < 4; lane++) begin
                        if (reqByteEn[lane]) begin
                            centerFreq[lane*8 +: 8] <= reqData[lane*8 +: 8];
                        end
                    end
                end
                `PLL_REG_GAIN: begin
                    if (reqByteEn[0]) begin
                        loopGain <= reqData[`PLL_GAIN_WIDTH-1:0];  // gain sits in lane 0.
                    end
                end
                default: ;  // the status offsets are read only.
            endcase
        end
    end

    // ====================
    // read path
    // ====================
    always_comb begin
        case (reqAddr)
            `PLL_REG_CENTER_FREQ: readData = centerFreq;
            `PLL_REG_GAIN:        readData = {{(32-`PLL_GAIN_WIDTH){1'b0}}, loopGain};
            `PLL_REG_PHASE_ERROR: begin
                readData = {{(32-`PLL_ERROR_WIDTH){phaseError[`PLL_ERROR_WIDTH-1]}},
                            phaseError};
            end
            `PLL_REG_PHASE_INC:   readData = phaseInc;
            default:              readData = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rspValid <= 1'b0;
        end else if (readFire) begin
            rspValid <= 1'b1;
        end else if (rspReady) begin
            rspValid <= 1'b0;  // response taken and nothing new behind it.
        end
    end

    always_ff @(posedge clk) begin
        if (readFire) begin
            rspData <= readData;  // held while the host stalls.
        end
    end

endmodule

`default_nettype wire

/* hw/phaseComparator.sv */
`timescale 1ns/1ns
`default_nettype none

module phaseComparator
    import pllLoopPkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        referenceClkEn,
    input  wire        outputClkEn,
    output phaseErrorT phaseError
);

    logic refOnly;
    logic outOnly;

    assign refOnly = referenceClkEn && !outputClkEn;
    assign outOnly = outputClkEn && !referenceClkEn;

    // A reference edge alone means the output lags, so the count drops.
    always_ff @(posedge clk) begin
        if (reset) begin
            phaseError <= '0;
        end else if (refOnly) begin
            phaseError <= phaseError - 1'b1;  // wraps through -128.
        end else if (outOnly) begin
            phaseError <= phaseError + 1'b1;  // wraps through 127.
        end
    end

endmodule

`default_nettype wire

/* hw/loopFilter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pll_params.svh"

module loopFilter
    import pllLoopPkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  phaseT      centerFreq,
    input  loopGainT   loopGain,
    input  phaseErrorT phaseError,
    output phaseT      phaseInc
);

    logic signed [`PLL_PHASE_WIDTH-1:0] errorExt;
    logic signed [`PLL_PHASE_WIDTH-1:0] leadNext;
    phaseT                              leadError;
    phaseT                              centerFreqQ;
    phaseT                              errorSum;

    assign errorExt = $signed({{(`PLL_PHASE_WIDTH-`PLL_ERROR_WIDTH){phaseError[7]}},
                               phaseError});

    // ====================
    // gain shifter
    // ====================
    // Code 7 passes the error unscaled; each step away doubles or halves it.
    always_comb begin
        if (loopGain == '0) begin
            leadNext = '0;
        end else if (loopGain >= 5'd7) begin
            leadNext = errorExt <<< (loopGain - 5'd7);
        end else begin
            leadNext = errorExt >>> (5'd7 - loopGain);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            leadError   <= '0;
            centerFreqQ <= '0;
        end else begin
            leadError   <= leadNext;
            centerFreqQ <= centerFreq;  // keeps both sum inputs on the same edge.
        end
    end

    // ====================
    // saturating sum
    // ====================
    assign errorSum = centerFreqQ + leadError;

    always_ff @(posedge clk) begin
        if (reset) begin
            phaseInc <= '0;
        end else if (errorSum[31] && !leadError[31]) begin
            phaseInc <= `PLL_INC_MAX;  // ran past the top of the range.
        end else if (errorSum[31] && leadError[31]) begin
            phaseInc <= `PLL_INC_MIN;  // pulled below zero.
        end else begin
            phaseInc <= errorSum;
        end
    end

endmodule

`default_nettype wire

/* hw/numericallyControlledOscillator.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pll_params.svh"

module numericallyControlledOscillator
    import pllLoopPkg::*;
(
    input  wire   clk,
    input  wire   reset,
    input  phaseT phaseInc,
    output logic  outputClk,
    output logic  outputClkEn
);

    phaseT      phase;
    phaseT      phaseSum;
    logic [1:0] topBitHistory;

    assign phaseSum = phase + phaseInc;  // wraps once per output period.

    always_ff @(posedge clk) begin
        if (reset) begin
            phase         <= '0;
            topBitHistory <= '0;
            outputClk     <= 1'b0;
            outputClkEn   <= 1'b0;
        end else begin
            phase         <= phaseSum;
            topBitHistory <= {topBitHistory[0], phaseSum[`PLL_PHASE_WIDTH-1]};
            outputClk     <= phase[`PLL_PHASE_WIDTH-1];  // square wave from the top bit.
            // one pulse per wrap of the accumulator.
            outputClkEn   <= (topBitHistory == 2'b10);
        end
    end

endmodule

`default_nettype wire

/* hw/digitalPll.sv */
`timescale 1ns/1ns
`default_nettype none

module digitalPll
    import pllBusPkg::*, pllLoopPkg::*;
(
    input  wire        clk,
    input  wire        reset,

    input  wire        reqValid,
    input  wire        reqWrite,
    input  regAddrT    reqAddr,
    input  byteEnT     reqByteEn,
    input  busDataT    reqData,
    output logic       reqReady,
    output logic       rspValid,
    output busDataT    rspData,
    input  wire        rspReady,

    input  wire        referenceClkEn,
    output logic       outputClk,
    output logic       outputClkEn,
    output phaseErrorT phaseError
);

    phaseT    centerFreq;
    loopGainT loopGain;
    phaseT    phaseInc;

    // ====================
    // host registers
    // ====================
    pllRegisterFile regFile (
        .clk        (clk),
        .reset      (reset),
        .reqValid   (reqValid),
        .reqWrite   (reqWrite),
        .reqAddr    (reqAddr),
        .reqByteEn  (reqByteEn),
        .reqData    (reqData),
        .reqReady   (reqReady),
        .rspValid   (rspValid),
        .rspData    (rspData),
        .rspReady   (rspReady),
        .phaseError (phaseError),
        .phaseInc   (phaseInc),
        .centerFreq (centerFreq),
        .loopGain   (loopGain)
    );

    // ====================
    // loop
    // ====================
    phaseComparator comparator (
        .clk            (clk),
        .reset          (reset),
        .referenceClkEn (referenceClkEn),
        .outputClkEn    (outputClkEn),  // the oscillator closes the loop here.
        .phaseError     (phaseError)
    );

    loopFilter filter (
        .clk        (clk),
        .reset      (reset),
        .centerFreq (centerFreq),
        .loopGain   (loopGain),
        .phaseError (phaseError),
        .phaseInc   (phaseInc)
    );

    numericallyControlledOscillator nco (
        .clk         (clk),
        .reset       (reset),
        .phaseInc    (phaseInc),
        .outputClk   (outputClk),
        .outputClkEn (outputClkEn)
    );

endmodule

`default_nettype wire

/* testbench/pllChecker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pll_params.svh"

module pllChecker
    import pllBusPkg::*, pllLoopPkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        reqValid,
    input  wire        reqWrite,
    input  regAddrT    reqAddr,
    input  byteEnT     reqByteEn,
    input  busDataT    reqData,
    input  wire        reqReady,
    input  wire        rspValid,
    input  busDataT    rspData,
    input  wire        rspReady,
    input  wire        referenceClkEn,
    input  wire        outputClkEn,
    input  phaseErrorT phaseError,
    output int         errorCount
);

    phaseT      shadowCenter;
    loopGainT   shadowGain;
    phaseErrorT errorModel;
    phaseErrorT errorPrev;
    busDataT    expectQ[$];  // one entry per accepted read, in request order.
    logic       checkQ[$];   // offset 3 depends on the filter, so it is not modelled here.
    busDataT    expected;
    logic       checkIt;
    logic       stalled;
    busDataT    heldData;
    logic       readLast;

    always @(posedge clk) begin
        if (reset) begin
            shadowCenter = '0;
            shadowGain   = '0;
            errorModel   = '0;
            errorPrev    = '0;
            stalled      = 1'b0;
            readLast     = 1'b0;
            errorCount   = 0;
            expectQ.delete();
            checkQ.delete();
        end else begin
            // ====================
            // phase comparator
            // ====================
            if (phaseError !== errorModel) begin
                $display("mismatch phaseError: got %h expected %h", phaseError, errorModel);
                errorCount++;
            end
            errorPrev = errorModel;  // value a read accepted on this edge returns.
            if (referenceClkEn && !outputClkEn) begin
                errorModel = errorModel - 8'sd1;
            end else if (outputClkEn && !referenceClkEn) begin
                errorModel = errorModel + 8'sd1;
            end

            // ====================
            // response protocol
            // ====================
            if (readLast && !rspValid) begin
                $display("no response in the cycle after an accepted read");
                errorCount++;
            end
            if (stalled && (!rspValid || rspData !== heldData)) begin
                $display("response dropped or changed while the host stalled");
                errorCount++;
            end
            if (rspValid && !rspReady && reqReady) begin
                $display("request side ready while a response is stalled");
                errorCount++;
            end
            if (rspValid && rspReady) begin
                if (expectQ.size() == 0) begin
                    $display("response arrived without a pending read");
                    errorCount++;
                end else begin
                    expected = expectQ.pop_front();
                    checkIt  = checkQ.pop_front();
                    if (checkIt && rspData !== expected) begin
                        $display("mismatch rspData: got %h expected %h", rspData, expected);
                        errorCount++;
                    end
                end
            end
            stalled  = rspValid && !rspReady;
            heldData = rspData;
            readLast = reqValid && reqReady && !reqWrite;

            // ====================
            // register shadow
            // ====================
            if (reqValid && reqReady && reqWrite) begin
                if (reqAddr == `PLL_REG_CENTER_FREQ) begin
                    for (int lane = 0; lane < 4; lane++) begin
                        if (reqByteEn[lane]) shadowCenter[lane*8 +: 8] = reqData[lane*8 +: 8];
                    end
                end else if (reqAddr == `PLL_REG_GAIN && reqByteEn[0]) begin
                    shadowGain = reqData[4:0];
                end
            end else if (reqValid && reqReady) begin
                checkIt  = 1'b1;
                expected = '0;  // unknown offsets read as zero.
                case (reqAddr)
                    `PLL_REG_CENTER_FREQ: expected = shadowCenter;
                    `PLL_REG_GAIN:        expected = {27'd0, shadowGain};
                    `PLL_REG_PHASE_ERROR: expected = {{24{errorPrev[7]}}, errorPrev};
                    `PLL_REG_PHASE_INC:   checkIt = 1'b0;
                    default: ;
                endcase
                expectQ.push_back(expected);
                checkQ.push_back(checkIt);
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/digitalPllTb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pll_params.svh"

module digitalPllTb;

    import pllBusPkg::*, pllLoopPkg::*;

    // about 900 cycles of register traffic, 1000 of frequency window and 400 of saturation.
    localparam int CycleLimit = 4000;
    localparam int Window     = 1000;

    logic clk = 1'b0;
    logic reset;
    logic reqValid, reqWrite, reqReady, rspValid, rspReady;
    logic referenceClkEn, outputClk, outputClkEn;
    regAddrT    reqAddr;
    byteEnT     reqByteEn;
    busDataT    reqData, rspData, readBack, drawn;
    phaseErrorT phaseError;
    int checkErrors, testErrors, cycleCount, pulses, rises, negativeRun;
    logic        clkLast;
    logic [15:0] seqLfsr = 16'd33499;
    logic [15:0] bgLfsr  = 16'd33499;
    logic [1:0]  refMode;  // 0 random, 1 held low, 2 held high.
    logic [1:0]  stallLeft;
    logic [31:0] stallDraw, refDraw;

    always #50 clk = ~clk;

    digitalPll uut (.*);

    pllChecker monitor (.*, .errorCount(checkErrors));

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken.
    function automatic logic [31:0] takeBits(inout logic [15:0] state, input int count);
        logic [31:0] bits;
        logic        feedback;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
            state    = {state[14:0], feedback};
            bits     = {bits[30:0], feedback};
        end
        return bits;
    endfunction

    // a count over the window may be one off from window * freq / 2^32.
    function automatic logic nearExpectedCount(input int count, input busDataT freq);
        longint slack;
        slack = longint'(count) * (64'sd1 <<< 32) - longint'(Window) * longint'(freq);
        return (slack <= (64'sd1 <<< 32)) && (slack >= -(64'sd1 <<< 32));
    endfunction

    task automatic sendRequest(input logic write, input regAddrT addr, input byteEnT be,
                               input busDataT data);
        reqValid  <= 1'b1;
        reqWrite  <= write;
        reqAddr   <= addr;
        reqByteEn <= be;
        reqData   <= data;
        @(posedge clk);
        while (!reqReady) @(posedge clk);
        reqValid <= 1'b0;
    endtask

    task automatic readRegister(input regAddrT addr, output busDataT data);
        sendRequest(1'b0, addr, 4'h0, '0);
        while (!(rspValid && rspReady)) @(posedge clk);
        data = rspData;
    endtask

    // ====================
    // background stimulus
    // ====================
    always @(posedge clk) begin
        stallDraw = takeBits(bgLfsr, 3);
        refDraw   = takeBits(bgLfsr, 2);
        if (reset) begin
            rspReady       <= 1'b1;
            referenceClkEn <= 1'b0;
            stallLeft      <= '0;
        end else begin
            if (stallLeft != 0) begin
                rspReady  <= 1'b0;
                stallLeft <= stallLeft - 1'b1;
            end else if (stallDraw[2] && stallDraw[1:0] != 0) begin
                rspReady  <= 1'b0;
                stallLeft <= stallDraw[1:0] - 1'b1;
            end else begin
                rspReady <= 1'b1;
            end
            referenceClkEn <= (refMode == 2'd2) || (refMode == 2'd0 && refDraw[1:0] == 0);
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CycleLimit) begin
            $display("timeout after %0d cycles", cycleCount);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        reqValid = 1'b0;
        reqWrite = 1'b0;
        reqAddr = '0;
        reqByteEn = '0;
        reqData = '0;
        rspReady = 1'b1;
        referenceClkEn = 1'b0;
        refMode = 2'd0;
        testErrors = 0;
        cycleCount = 0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // register round trip, mostly the four known offsets.
        repeat (60) begin
            drawn = takeBits(seqLfsr, 5);
            reqAddr <= drawn[4] ? regAddrT'(drawn[3:0]) : regAddrT'(drawn[1:0]);
            @(posedge clk);
            sendRequest(1'b1, reqAddr, byteEnT'(takeBits(seqLfsr, 4)), takeBits(seqLfsr, 32));
            readRegister(reqAddr, readBack);
        end

        // free-running frequency with the loop open.
        refMode <= 2'd1;
        sendRequest(1'b1, `PLL_REG_GAIN, 4'h1, 32'd0);
        drawn = takeBits(seqLfsr, 31);  // top bit stays clear.
        sendRequest(1'b1, `PLL_REG_CENTER_FREQ, 4'hF, drawn);
        repeat (4) @(posedge clk);
        pulses = 0;
        rises = 0;
        clkLast = outputClk;
        repeat (Window) begin
            @(posedge clk);
            if (outputClkEn) pulses++;
            if (outputClk && !clkLast) rises++;
            clkLast = outputClk;
        end
        if (!nearExpectedCount(pulses, drawn)) begin
            $display("output pulse count %0d is off for center frequency %h", pulses, drawn);
            testErrors++;
        end
        if (!nearExpectedCount(rises, drawn)) begin
            $display("output clock rise count %0d is off for center frequency %h", rises, drawn);
            testErrors++;
        end

        // saturation at the top, then at zero.
        sendRequest(1'b1, `PLL_REG_CENTER_FREQ, 4'hF, 32'h8000_0000 | takeBits(seqLfsr, 31));
        repeat (4) @(posedge clk);
        readRegister(`PLL_REG_PHASE_INC, readBack);
        if (readBack !== 32'h7FFF_FFFF) begin
            $display("mismatch phaseInc: got %h expected %h", readBack, 32'h7FFF_FFFF);
            testErrors++;
        end
        sendRequest(1'b1, `PLL_REG_CENTER_FREQ, 4'hF, takeBits(seqLfsr, 24));
        sendRequest(1'b1, `PLL_REG_GAIN, 4'h1, 32'd31);
        refMode <= 2'd2;
        negativeRun = 0;
        while (negativeRun < 3) begin
            @(posedge clk);
            negativeRun = phaseError[7] ? negativeRun + 1 : 0;
        end
        readRegister(`PLL_REG_PHASE_INC, readBack);
        if (readBack !== 32'h0) begin
            $display("mismatch phaseInc: got %h expected %h", readBack, 32'h0);
            testErrors++;
        end

        repeat (4) @(posedge clk);
        $display("checker errors %0d, test errors %0d", checkErrors, testErrors);
        if (checkErrors == 0 && testErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+hw
hw/pllBusPkg.sv
hw/pllLoopPkg.sv
hw/pllRegisterFile.sv
hw/phaseComparator.sv
hw/loopFilter.sv
hw/numericallyControlledOscillator.sv
hw/digitalPll.sv
testbench/pllChecker.sv
testbench/digitalPllTb.sv
